//--- Bender.yml
package:
  name: tusca

sources:
  - target: any(rtl, test)
    files:
      - verilog/tusca_medida_pkg.sv
      - verilog/tusca_config_pkg.sv
      - verilog/tusca_uc.sv
      - verilog/tusca_interface_dht11.sv
      - verilog/tusca_recepcao_config.sv
      - verilog/tusca_atuadores.sv
      - verilog/tusca.sv
  - target: test
    files:
      - verif/tusca_sva.sv
      - verif/tusca_tb.sv

//--- files.f
verilog/tusca_medida_pkg.sv
verilog/tusca_config_pkg.sv
verilog/tusca_uc.sv
verilog/tusca_interface_dht11.sv
verilog/tusca_recepcao_config.sv
verilog/tusca_atuadores.sv
verilog/tusca.sv
verif/tusca_sva.sv
verif/tusca_tb.sv

//--- verif/tusca_sva.sv
module tusca_sva (
  input logic clock,
  input logic arst_n,
  input logic medir,
  input logic pronto_medida,
  input logic dht_bus
);

  timeunit 1ns;
  timeprecision 100ps;

  // the start pulse and 83 bus phases, each cut off by the timeout, bound one measurement.
  localparam int unsigned ESPERA_MAX = tusca_medida_pkg::CICLOS_PULSO_INICIO
                                     + 84 * tusca_medida_pkg::CICLOS_TIMEOUT;

  logic        pendente;
  logic [31:0] espera;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      pendente <= 1'b0;
      espera   <= '0;
    end else begin
      if (medir) begin
        pendente <= 1'b1;
      end else if (pronto_medida) begin
        pendente <= 1'b0;
      end
      espera <= pendente ? espera + 1 : '0;
    end
  end

  a_medir_unico: assert property (@(posedge clock) disable iff (!arst_n)
    medir |-> !pendente)
    else $error("medir issued while a measurement is still pending");

  a_pronto_com_pedido: assert property (@(posedge clock) disable iff (!arst_n)
    pronto_medida |-> pendente)
    else $error("pronto_medida without an earlier medir");

  a_resposta_limitada: assert property (@(posedge clock) disable iff (!arst_n)
    pendente |-> espera < ESPERA_MAX)
    else $error("no pronto_medida after medir");

  // a high driver fighting a low one leaves the open-drain line unknown.
  a_bus_sem_conflito: assert property (@(posedge clock) disable iff (!arst_n)
    !$isunknown(dht_bus))
    else $error("dht_bus driven high against a low driver");

endmodule

bind tusca_interface_dht11 tusca_sva sva_i (
  .clock         (clock),
  .arst_n        (arst_n),
  .medir         (medir),
  .pronto_medida (pronto_medida),
  .dht_bus       (dht_bus)
);

//--- verif/tusca_tb.sv
module tusca_tb;

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic       tem_cfg;
    logic [7:0] opcode;
    logic [7:0] valor;
    logic       gira;
    logic [7:0] temperatura;
    logic [7:0] umidade;
    logic       corrompe;
  } linha_t;

  localparam int N_LINHAS   = 12;
  localparam int ESPERA_MAX = 250000;

  logic       clock;
  logic       arst_n;
  logic       start;
  logic       gira;
  logic       rx_serial_config;
  logic       sensor_baixo;
  wire        dht_bus;
  logic       erro_config;
  logic       erro_medida;
  logic       rele;
  logic       pwm_ventoinha;
  logic       pwm_servo;
  logic [2:0] nivel_temperatura;

  linha_t     tabela [N_LINHAS];
  logic [7:0] lim_temp [1:4];
  logic [7:0] lim_umidade;
  logic [7:0] temp_valida;
  logic [7:0] umid_valida;
  logic       erro_config_esp;
  int         falhas = 0;
  int         testes_ok = 0;
  int         testes_falha = 0;
  int         largura_corrente = 0;
  int         largura_servo_ult = 0;
  time        inicio_corrente = 0;
  time        inicio_servo_ult = 0;

  // the sensor only pulls low, the pull-up stands in for the board resistor.
  pullup (dht_bus);
  assign dht_bus = sensor_baixo ? 1'b0 : 1'bz;

  tusca dut_i (
    .clock             (clock),
    .arst_n            (arst_n),
    .start             (start),
    .gira              (gira),
    .rx_serial_config  (rx_serial_config),
    .dht_bus           (dht_bus),
    .erro_config       (erro_config),
    .erro_medida       (erro_medida),
    .rele              (rele),
    .pwm_ventoinha     (pwm_ventoinha),
    .pwm_servo         (pwm_servo),
    .nivel_temperatura (nivel_temperatura)
  );

  always #50 clock = ~clock;

  // width in cycles and start time of the last complete servo pulse.
  always @(negedge clock) begin
    if (pwm_servo === 1'b1) begin
      if (largura_corrente == 0) begin
        inicio_corrente = $time;
      end
      largura_corrente = largura_corrente + 1;
    end else if (largura_corrente != 0) begin
      largura_servo_ult = largura_corrente;
      inicio_servo_ult  = inicio_corrente;
      largura_corrente  = 0;
    end
  end

  task automatic check_value(input string nome, input logic [31:0] obtido,
                             input logic [31:0] esperado);
    assert (obtido == esperado) else begin
      $display("FAIL t=%0t %s: got %0d, expected %0d", $time, nome, obtido, esperado);
      falhas++;
    end
  endtask

  task automatic finish_test(input string nome);
    if (falhas == 0) begin
      $display("%s: ok", nome);
      testes_ok++;
    end else begin
      $display("%s: %0d check(s) failed", nome, falhas);
      testes_falha++;
    end
    falhas = 0;
  endtask

  task automatic wait_bus(input logic nivel, input string motivo);
    int n;
    n = 0;
    while (dht_bus !== nivel && n < ESPERA_MAX) begin
      @(negedge clock);
      n++;
    end
    assert (dht_bus === nivel) else begin
      $display("timed out at t=%0t waiting for %s", $time, motivo);
      falhas++;
    end
  endtask

  task automatic send_uart_byte(input logic [7:0] dado);
    logic [9:0] quadro;
    quadro = {1'b1, dado, 1'b0};
    @(negedge clock);
    for (int i = 0; i < 10; i++) begin
      rx_serial_config = quadro[i];
      repeat (tusca_config_pkg::CICLOS_BIT_UART) @(negedge clock);
    end
  endtask

  // model of the limit registers. A pair with an unknown opcode only raises the error.
  task automatic update_limits(input logic [7:0] op, input logic [7:0] valor);
    erro_config_esp = 1'b0;
    case (op)
      8'd1, 8'd2, 8'd3, 8'd4: lim_temp[op] = valor;
      8'd5:                   lim_umidade = valor;
      default:                erro_config_esp = 1'b1;
    endcase
  endtask

  function automatic int expected_level(input logic [7:0] temp);
    int n;
    n = 0;
    for (int k = 1; k <= 4; k++) begin
      if (temp > lim_temp[k]) begin
        n++;
      end
    end
    return n;
  endfunction

  // answers one host start pulse with a full 40 bit frame.
  task automatic serve_sensor_frame(input linha_t l, output time fim);
    logic [7:0]  umid_dec;
    logic [7:0]  temp_dec;
    logic [7:0]  soma;
    logic [39:0] quadro;
    umid_dec = 8'($urandom % 10);
    temp_dec = 8'($urandom % 10);
    soma     = l.umidade + umid_dec + l.temperatura + temp_dec;
    if (l.corrompe) begin
      soma = soma + 8'd1;
    end
    quadro = {l.umidade, umid_dec, l.temperatura, temp_dec, soma};
    wait_bus(1'b0, "the host start pulse");
    wait_bus(1'b1, "the host to release the bus");
    #30000 sensor_baixo = 1'b1;
    #80000 sensor_baixo = 1'b0;
    #80000;
    for (int i = 39; i >= 0; i--) begin
      sensor_baixo = 1'b1;
      #50000 sensor_baixo = 1'b0;
      #(quadro[i] ? 70000 : 27000);
    end
    sensor_baixo = 1'b1;
    #50000 sensor_baixo = 1'b0;
    fim = $time;
  endtask

  initial begin
    int  n;
    int  vent_alto;
    int  nivel_esp;
    int  servo_esp;
    time fim_frame;
    clock            = 1'b0;
    arst_n           = 1'b0;
    start            = 1'b0;
    gira             = 1'b0;
    rx_serial_config = 1'b1;
    sensor_baixo     = 1'b0;
    void'($urandom(59668));
    tabela[0]  = '{1'b0, 8'd0, 8'd0,  1'b1, 8'd18, 8'd60, 1'b0};
    tabela[1]  = '{1'b0, 8'd0, 8'd0,  1'b1, 8'd22, 8'd75, 1'b0};
    tabela[2]  = '{1'b0, 8'd0, 8'd0,  1'b0, 8'd27, 8'd70, 1'b0};
    tabela[3]  = '{1'b0, 8'd0, 8'd0,  1'b1, 8'd32, 8'd71, 1'b0};
    tabela[4]  = '{1'b0, 8'd0, 8'd0,  1'b1, 8'd40, 8'd40, 1'b0};
    tabela[5]  = '{1'b1, 8'd5, 8'd50, 1'b1, 8'd27, 8'd55, 1'b0};
    tabela[6]  = '{1'b0, 8'd0, 8'd0,  1'b1, 8'd27, 8'd50, 1'b0};
    tabela[7]  = '{1'b1, 8'd2, 8'd28, 1'b1, 8'd27, 8'd60, 1'b0};
    tabela[8]  = '{1'b1, 8'd9, 8'd10, 1'b0, 8'd27, 8'd60, 1'b0};
    tabela[9]  = '{1'b1, 8'd1, 8'd20, 1'b1, 8'd27, 8'd60, 1'b0};
    tabela[10] = '{1'b0, 8'd0, 8'd0,  1'b1, 8'd33, 8'd40, 1'b1};
    tabela[11] = '{1'b0, 8'd0, 8'd0,  1'b1, 8'd33, 8'd45, 1'b0};
    lim_temp[1]     = 8'd20;
    lim_temp[2]     = 8'd25;
    lim_temp[3]     = 8'd30;
    lim_temp[4]     = 8'd35;
    lim_umidade     = 8'd70;
    erro_config_esp = 1'b0;
    temp_valida     = 8'd0;
    umid_valida     = 8'd0;

    repeat (8) @(negedge clock);
    arst_n = 1'b1;
    repeat (20) begin
      @(negedge clock);
      check_value("outputs after reset", {erro_config, erro_medida, rele, pwm_ventoinha,
                                          pwm_servo, nivel_temperatura}, 0);
      check_value("dht_bus after reset", dht_bus, 1);
    end
    start = 1'b1;
    n = 0;
    while (dht_bus !== 1'b0 && n < 10) begin
      @(negedge clock);
      n++;
    end
    check_value("cycles from start to host pulse", n, 2);
    finish_test("power-up and start");

    for (int i = 0; i < N_LINHAS; i++) begin
      gira = tabela[i].gira;
      if (tabela[i].tem_cfg) begin
        send_uart_byte(tabela[i].opcode);
        send_uart_byte(tabela[i].valor);
        update_limits(tabela[i].opcode, tabela[i].valor);
      end
      serve_sensor_frame(tabela[i], fim_frame);
      if (!tabela[i].corrompe) begin
        temp_valida = tabela[i].temperatura;
        umid_valida = tabela[i].umidade;
      end
      // the next start pulse comes a full interval after the frame.
      wait_bus(1'b0, "the next host start pulse");
      nivel_esp = expected_level(temp_valida);
      check_value("nivel_temperatura", nivel_temperatura, nivel_esp);
      check_value("rele", rele, umid_valida > lim_umidade);
      check_value("erro_medida", erro_medida, tabela[i].corrompe);
      check_value("erro_config", erro_config, erro_config_esp);
      vent_alto = 0;
      repeat (tusca_config_pkg::CICLOS_PWM_VENTOINHA) begin
        @(negedge clock);
        if (pwm_ventoinha === 1'b1) begin
          vent_alto++;
        end
      end
      check_value("pwm_ventoinha high cycles", vent_alto, 25 * nivel_esp);
      if (tabela[i].gira) begin
        servo_esp = tusca_config_pkg::CICLOS_SERVO_BASE
                  + tusca_config_pkg::CICLOS_SERVO_PASSO * nivel_esp;
      end else begin
        servo_esp = tusca_config_pkg::CICLOS_SERVO_NEUTRO;
      end
      // only a pulse that began after the frame carries the new level.
      n = 0;
      while (inicio_servo_ult <= fim_frame && n < ESPERA_MAX) begin
        @(negedge clock);
        n++;
      end
      assert (inicio_servo_ult > fim_frame) else begin
        $display("no servo pulse at t=%0t after the frame of row %0d", $time, i);
        falhas++;
      end
      check_value("pwm_servo high cycles", largura_servo_ult, servo_esp);
      finish_test($sformatf("row %0d", i));
    end

    $display("tests passed: %0d, failed: %0d", testes_ok, testes_falha);
    if (testes_falha == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(N_LINHAS * 45_000_000 + 10_000_000);
    $display("watchdog expired before all rows were applied");
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- verilog/tusca.sv
module tusca (
  input  logic       clock,
  input  logic       arst_n,
  input  logic       start,
  input  logic       gira,
  input  logic       rx_serial_config,
  inout  wire        dht_bus,
  output logic       erro_config,
  output logic       erro_medida,
  output logic       rele,
  output logic       pwm_ventoinha,
  output logic       pwm_servo,
  output logic [2:0] nivel_temperatura
);

  logic                       medir;
  logic                       pronto_medida;
  logic                       erro_medida_pulso;
  tusca_medida_pkg::medida_t  medida;
  tusca_config_pkg::limites_t limites;

  tusca_uc uc (
    .clock         (clock),
    .arst_n        (arst_n),
    .start         (start),
    .pronto_medida (pronto_medida),
    .medir         (medir)
  );

  tusca_interface_dht11 dht11 (
    .clock             (clock),
    .arst_n            (arst_n),
    .medir             (medir),
    .dht_bus           (dht_bus),
    .pronto_medida     (pronto_medida),
    .erro_medida_pulso (erro_medida_pulso),
    .medida            (medida)
  );

  tusca_recepcao_config recepcao_config (
    .clock            (clock),
    .arst_n           (arst_n),
    .rx_serial_config (rx_serial_config),
    .limites          (limites),
    .erro_config      (erro_config)
  );

  tusca_atuadores atuadores (
    .clock             (clock),
    .arst_n            (arst_n),
    .gira              (gira),
    .pronto_medida     (pronto_medida),
    .erro_medida_pulso (erro_medida_pulso),
    .medida            (medida),
    .limites           (limites),
    .nivel_temperatura (nivel_temperatura),
    .rele              (rele),
    .erro_medida       (erro_medida),
    .pwm_ventoinha     (pwm_ventoinha),
    .pwm_servo         (pwm_servo)
  );

endmodule

//--- verilog/tusca_atuadores.sv
module tusca_atuadores (
  input  logic                       clock,
  input  logic                       arst_n,
  input  logic                       gira,
  input  logic                       pronto_medida,
  input  logic                       erro_medida_pulso,
  input  tusca_medida_pkg::medida_t  medida,
  input  tusca_config_pkg::limites_t limites,
  output logic [2:0]                 nivel_temperatura,
  output logic                       rele,
  output logic                       erro_medida,
  output logic                       pwm_ventoinha,
  output logic                       pwm_servo
);

  tusca_medida_pkg::medida_t medida_q;
  logic                      medida_valida;
  logic [6:0]                cnt_vent;
  logic [6:0]                duty_vent;
  logic [17:0]               cnt_servo;
  logic [17:0]               duty_servo;
  logic [17:0]               largura_servo;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      medida_q      <= '0;
      medida_valida <= 1'b0;
      erro_medida   <= 1'b0;
    end else if (pronto_medida) begin
      erro_medida <= erro_medida_pulso;
      if (!erro_medida_pulso) begin
        medida_q      <= medida;
        medida_valida <= 1'b1;
      end
    end
  end

  // level counts the limits the temperature is strictly above.
  assign nivel_temperatura = {2'b00, medida_q.temperatura_int > limites.lim_temp1}
                           + {2'b00, medida_q.temperatura_int > limites.lim_temp2}
                           + {2'b00, medida_q.temperatura_int > limites.lim_temp3}
                           + {2'b00, medida_q.temperatura_int > limites.lim_temp4};
  assign rele = medida_q.umidade_int > limites.lim_umidade;

  // the servo stays idle until the first good frame.
  assign largura_servo = !medida_valida ? 18'd0
                       : gira ? 18'(tusca_config_pkg::CICLOS_SERVO_BASE)
                              + 18'(tusca_config_pkg::CICLOS_SERVO_PASSO)
                              * 18'(nivel_temperatura)
                       : 18'(tusca_config_pkg::CICLOS_SERVO_NEUTRO);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      cnt_vent   <= '0;
      duty_vent  <= '0;
      cnt_servo  <= '0;
      duty_servo <= '0;
    end else begin
      if (cnt_vent == 7'(tusca_config_pkg::CICLOS_PWM_VENTOINHA - 1)) begin
        cnt_vent  <= '0;
        duty_vent <= 7'd25 * 7'(nivel_temperatura);
      end else begin
        cnt_vent <= cnt_vent + 1;
      end
      if (cnt_servo == 18'(tusca_config_pkg::CICLOS_PWM_SERVO - 1)) begin
        cnt_servo  <= '0;
        duty_servo <= largura_servo;
      end else begin
        cnt_servo <= cnt_servo + 1;
      end
    end
  end

  assign pwm_ventoinha = (cnt_vent < duty_vent);
  assign pwm_servo     = (cnt_servo < duty_servo);

endmodule

//--- verilog/tusca_config_pkg.sv
package tusca_config_pkg;

  typedef enum logic [7:0] {
    CFG_LIM_TEMP1   = 8'd1,
    CFG_LIM_TEMP2   = 8'd2,
    CFG_LIM_TEMP3   = 8'd3,
    CFG_LIM_TEMP4   = 8'd4,
    CFG_LIM_UMIDADE = 8'd5
  } opcode_config_t;

  // temperature limits in degrees, humidity limit in percent.
  typedef struct packed {
    logic [7:0] lim_temp1;
    logic [7:0] lim_temp2;
    logic [7:0] lim_temp3;
    logic [7:0] lim_temp4;
    logic [7:0] lim_umidade;
  } limites_t;

  localparam limites_t LIMITES_RESET = '{
    lim_temp1:   8'd20,
    lim_temp2:   8'd25,
    lim_temp3:   8'd30,
    lim_temp4:   8'd35,
    lim_umidade: 8'd70
  };

  localparam int unsigned CICLOS_BIT_UART      = 87;
  localparam int unsigned CICLOS_PWM_VENTOINHA = 100;

  // servo pulse widths within a 20 ms frame.
  localparam int unsigned CICLOS_PWM_SERVO    = 200000;
  localparam int unsigned CICLOS_SERVO_BASE   = 10000;
  localparam int unsigned CICLOS_SERVO_PASSO  = 2500;
  localparam int unsigned CICLOS_SERVO_NEUTRO = 15000;

endpackage

//--- verilog/tusca_interface_dht11.sv
module tusca_interface_dht11 (
  input  logic                      clock,
  input  logic                      arst_n,
  input  logic                      medir,
  inout  wire                       dht_bus,
  output logic                      pronto_medida,
  output logic                      erro_medida_pulso,
  output tusca_medida_pkg::medida_t medida
);

  tusca_medida_pkg::estado_dht_t estado;
  logic                          bus_meta;
  logic                          bus_sync;
  logic                          bus_ant;
  logic                          desce;
  logic                          sobe;
  logic                          estouro;
  logic [31:0]                   contador;
  logic [5:0]                    bits_lidos;
  logic [39:0]                   dados;
  logic [7:0]                    soma;
  logic                          erro_timeout;

  // the host only pulls low, the pull-up brings the line back high.
  assign dht_bus = (estado == tusca_medida_pkg::DHT_PULSO_INICIO) ? 1'b0 : 1'bz;

  assign desce   = bus_ant & ~bus_sync;
  assign sobe    = ~bus_ant & bus_sync;
  assign estouro = (contador == tusca_medida_pkg::CICLOS_TIMEOUT - 1);

  assign soma              = dados[39:32] + dados[31:24] + dados[23:16] + dados[15:8];
  assign pronto_medida     = (estado == tusca_medida_pkg::DHT_FIM);
  assign erro_medida_pulso = pronto_medida & (erro_timeout | (soma != dados[7:0]));
  assign medida            = tusca_medida_pkg::medida_t'(dados[39:8]);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      bus_meta <= 1'b1;
      bus_sync <= 1'b1;
      bus_ant  <= 1'b1;
    end else begin
      bus_meta <= dht_bus;
      bus_sync <= bus_meta;
      bus_ant  <= bus_sync;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      estado       <= tusca_medida_pkg::DHT_OCIOSO;
      contador     <= '0;
      bits_lidos   <= '0;
      erro_timeout <= 1'b0;
    end else begin
      contador <= contador + 1;
      case (estado)
        tusca_medida_pkg::DHT_OCIOSO: begin
          contador <= '0;
          if (medir) begin
            erro_timeout <= 1'b0;
            bits_lidos   <= '0;
            estado       <= tusca_medida_pkg::DHT_PULSO_INICIO;
          end
        end
        tusca_medida_pkg::DHT_PULSO_INICIO: begin
          if (contador == tusca_medida_pkg::CICLOS_PULSO_INICIO - 1) begin
            contador <= '0;
            estado   <= tusca_medida_pkg::DHT_ESPERA_RESPOSTA;
          end
        end
        tusca_medida_pkg::DHT_ESPERA_RESPOSTA, tusca_medida_pkg::DHT_RESPOSTA,
        tusca_medida_pkg::DHT_BIT_BAIXO, tusca_medida_pkg::DHT_BIT_ALTO: begin
          if (estado == tusca_medida_pkg::DHT_ESPERA_RESPOSTA && desce) begin
            contador <= '0;
            estado   <= tusca_medida_pkg::DHT_RESPOSTA;
          end else if (estado == tusca_medida_pkg::DHT_RESPOSTA && (desce || sobe)) begin
            // the response is 80 us low then 80 us high, each phase timed apart.
            contador <= '0;
            if (desce) begin
              estado <= tusca_medida_pkg::DHT_BIT_BAIXO;
            end
          end else if (estado == tusca_medida_pkg::DHT_BIT_BAIXO && sobe) begin
            contador <= '0;
            estado   <= tusca_medida_pkg::DHT_BIT_ALTO;
          end else if (estado == tusca_medida_pkg::DHT_BIT_ALTO && desce) begin
            contador   <= '0;
            bits_lidos <= bits_lidos + 1;
            if (bits_lidos == 6'd39) begin
              estado <= tusca_medida_pkg::DHT_FIM;
            end else begin
              estado <= tusca_medida_pkg::DHT_BIT_BAIXO;
            end
          end else if (estouro) begin
            erro_timeout <= 1'b1;
            estado       <= tusca_medida_pkg::DHT_FIM;
          end
        end
        default: begin
          estado <= tusca_medida_pkg::DHT_OCIOSO;
        end
      endcase
    end
  end

  // a long high phase is a one, bits arrive msb first.
  always_ff @(posedge clock) begin
    if (estado == tusca_medida_pkg::DHT_BIT_ALTO && desce) begin
      dados <= {dados[38:0], contador > tusca_medida_pkg::CICLOS_LIMIAR_UM};
    end
  end

endmodule

//--- verilog/tusca_medida_pkg.sv
package tusca_medida_pkg;

  // sensor timing in cycles of the 10 MHz clock.
  localparam int unsigned CICLOS_PULSO_INICIO = 180000;
  localparam int unsigned CICLOS_LIMIAR_UM    = 400;
  localparam int unsigned CICLOS_TIMEOUT      = 1500;
  localparam int unsigned CICLOS_INTERVALO    = 200000;

  // one decoded frame in bus order, without the checksum byte.
  typedef struct packed {
    logic [7:0] umidade_int;
    logic [7:0] umidade_dec;
    logic [7:0] temperatura_int;
    logic [7:0] temperatura_dec;
  } medida_t;

  typedef enum logic [1:0] {
    UC_INICIAL,
    UC_MEDE,
    UC_ESPERA_MEDIDA,
    UC_ESPERA_INTERVALO
  } estado_uc_t;

  typedef enum logic [2:0] {
    DHT_OCIOSO,
    DHT_PULSO_INICIO,
    DHT_ESPERA_RESPOSTA,
    DHT_RESPOSTA,
    DHT_BIT_BAIXO,
    DHT_BIT_ALTO,
    DHT_FIM
  } estado_dht_t;

endpackage

//--- verilog/tusca_recepcao_config.sv
module tusca_recepcao_config (
  input  logic                       clock,
  input  logic                       arst_n,
  input  logic                       rx_serial_config,
  output tusca_config_pkg::limites_t limites,
  output logic                       erro_config
);

  typedef enum logic [1:0] {
    RX_OCIOSO,
    RX_INICIO,
    RX_DADOS,
    RX_PARADA
  } estado_rx_t;

  estado_rx_t                       estado;
  logic                             rx_meta;
  logic                             rx_sync;
  logic [6:0]                       contador;
  logic [2:0]                       indice;
  logic [7:0]                       byte_rx;
  logic                             meio_bit;
  logic                             fim_bit;
  logic                             byte_valido;
  logic                             tem_opcode;
  tusca_config_pkg::opcode_config_t opcode;

  assign meio_bit    = (contador == 7'(tusca_config_pkg::CICLOS_BIT_UART / 2 - 1));
  assign fim_bit     = (contador == 7'(tusca_config_pkg::CICLOS_BIT_UART - 1));
  assign byte_valido = (estado == RX_PARADA) && fim_bit && rx_sync;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      estado   <= RX_OCIOSO;
      contador <= '0;
      indice   <= '0;
    end else begin
      rx_meta  <= rx_serial_config;
      rx_sync  <= rx_meta;
      contador <= contador + 1;
      case (estado)
        RX_OCIOSO: begin
          contador <= '0;
          indice   <= '0;
          if (!rx_sync) begin
            estado <= RX_INICIO;
          end
        end
        RX_INICIO: begin
          // a start bit that is gone by mid-bit was a glitch.
          if (meio_bit) begin
            contador <= '0;
            estado   <= rx_sync ? RX_OCIOSO : RX_DADOS;
          end
        end
        RX_DADOS: begin
          if (fim_bit) begin
            contador <= '0;
            indice   <= indice + 1;
            if (indice == 3'd7) begin
              estado <= RX_PARADA;
            end
          end
        end
        default: begin
          if (fim_bit) begin
            estado <= RX_OCIOSO;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (estado == RX_DADOS && fim_bit) begin
      byte_rx <= {rx_sync, byte_rx[7:1]};
    end
    if (byte_valido && !tem_opcode) begin
      opcode <= tusca_config_pkg::opcode_config_t'(byte_rx);
    end
  end

  // first byte of a pair is the opcode, the second its value.
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      tem_opcode  <= 1'b0;
      erro_config <= 1'b0;
      limites     <= tusca_config_pkg::LIMITES_RESET;
    end else if (byte_valido) begin
      tem_opcode <= ~tem_opcode;
      if (tem_opcode) begin
        erro_config <= 1'b0;
        case (opcode)
          tusca_config_pkg::CFG_LIM_TEMP1:   limites.lim_temp1   <= byte_rx;
          tusca_config_pkg::CFG_LIM_TEMP2:   limites.lim_temp2   <= byte_rx;
          tusca_config_pkg::CFG_LIM_TEMP3:   limites.lim_temp3   <= byte_rx;
          tusca_config_pkg::CFG_LIM_TEMP4:   limites.lim_temp4   <= byte_rx;
          tusca_config_pkg::CFG_LIM_UMIDADE: limites.lim_umidade <= byte_rx;
          default:                           erro_config         <= 1'b1;
        endcase
      end
    end
  end

endmodule

//--- verilog/tusca_uc.sv
module tusca_uc (
  input  logic clock,
  input  logic arst_n,
  input  logic start,
  input  logic pronto_medida,
  output logic medir
);

  tusca_medida_pkg::estado_uc_t estado;
  logic                         start_q;
  logic                         borda_start;
  logic [31:0]                  contador;
  logic                         fim_intervalo;

  // only the first rising edge matters, later ones arrive while running.
  assign borda_start   = start & ~start_q;
  assign fim_intervalo = (contador == tusca_medida_pkg::CICLOS_INTERVALO - 1);
  assign medir         = (estado == tusca_medida_pkg::UC_MEDE);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      start_q <= 1'b0;
    end else begin
      start_q <= start;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      estado   <= tusca_medida_pkg::UC_INICIAL;
      contador <= '0;
    end else begin
      case (estado)
        tusca_medida_pkg::UC_INICIAL: begin
          if (borda_start) begin
            estado <= tusca_medida_pkg::UC_MEDE;
          end
        end
        tusca_medida_pkg::UC_MEDE: begin
          estado <= tusca_medida_pkg::UC_ESPERA_MEDIDA;
        end
        tusca_medida_pkg::UC_ESPERA_MEDIDA: begin
          if (pronto_medida) begin
            contador <= '0;
            estado   <= tusca_medida_pkg::UC_ESPERA_INTERVALO;
          end
        end
        tusca_medida_pkg::UC_ESPERA_INTERVALO: begin
          // the interval runs whether or not the last frame was good.
          if (fim_intervalo) begin
            estado <= tusca_medida_pkg::UC_MEDE;
          end else begin
            contador <= contador + 1;
          end
        end
        default: begin
          estado <= tusca_medida_pkg::UC_INICIAL;
        end
      endcase
    end
  end

endmodule
